// ==== hw/l1_icache_consts.svh ====
// Instruction cache geometry, field widths and refill beat count
`ifndef L1_ICACHE_CONSTS_SVH
`define L1_ICACHE_CONSTS_SVH

// Associativity and number of sets
`define L1I_WAYS 4
`define L1I_SETS 16

// A 64-byte line is moved as eight 8-byte beats
`define L1I_LINE_BEATS 8

// Address split: tag | set index | byte offset in line
`define L1I_TAG_W 22
`define L1I_INDEX_W 4
`define L1I_OFFSET_W 6

`endif

// ==== hw/l1_icache_pkg.sv ====
// Vector types and refill state encoding shared by the instruction cache blocks
`default_nettype none
`include "l1_icache_consts.svh"

package l1_icache_pkg;

	// Addresses and single instructions
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [11:0] mmu_flags_t;

	// One memory beat holds an instruction pair
	typedef logic [63:0] beat_t;
	typedef logic [23:0] beat_flags_t;

	// Whole line as stored in the array
	typedef logic [`L1I_LINE_BEATS*64-1:0] line_t;
	typedef logic [`L1I_LINE_BEATS*24-1:0] line_flags_t;

	// Address fields
	typedef logic [`L1I_TAG_W-1:0] tag_t;
	typedef logic [`L1I_INDEX_W-1:0] index_t;
	typedef logic [$clog2(`L1I_LINE_BEATS)-1:0] beat_idx_t;

	// Miss handling FSM
	typedef enum logic [1:0] {
		REFILL_IDLE,
		REFILL_REQ,
		REFILL_GET,
		REFILL_OUT
	} refill_state_t;

endpackage

`default_nettype wire

// ==== hw/l1_icache_if.sv ====
// Lookup result interface and line fill interface with their modports
`default_nettype none

interface l1_icache_lookup_if import l1_icache_pkg::*; ();

	// One pulse per lookup, held under next-stage lock
	logic valid;
	logic hit;
	beat_t data;
	beat_flags_t flags;

	modport source (
		output valid,
		output hit,
		output data,
		output flags
	);

	modport sink (
		input valid,
		input hit,
		input data,
		input flags
	);

endinterface

interface l1_icache_fill_if import l1_icache_pkg::*; ();

	// Single-cycle strobe writes a full line
	logic req;
	addr_t addr;
	line_t data;
	line_flags_t flags;

	modport master (
		output req,
		output addr,
		output data,
		output flags
	);

	modport slave (
		input req,
		input addr,
		input data,
		input flags
	);

endinterface

`default_nettype wire

// ==== hw/l1_icache_array.sv ====
// Tag, valid and data storage with registered lookup, line fill and flush
`default_nettype none
`include "l1_icache_consts.svh"

module l1_icache_array import l1_icache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic cache_flush,
	input logic rd_req,
	input addr_t rd_addr,
	input logic hold,
	l1_icache_lookup_if.source lookup,
	l1_icache_fill_if.slave fill
);

	localparam int WAY_W = $clog2(`L1I_WAYS);
	localparam int TAG_LSB = `L1I_INDEX_W + `L1I_OFFSET_W;

	// Storage
	tag_t tag_mem [`L1I_SETS][`L1I_WAYS];
	logic [`L1I_WAYS-1:0] valid_mem [`L1I_SETS];
	line_t data_mem [`L1I_SETS][`L1I_WAYS];
	line_flags_t flags_mem [`L1I_SETS][`L1I_WAYS];

	// Round-robin victim per set
	logic [WAY_W-1:0] victim [`L1I_SETS];

	tag_t rd_tag;
	index_t rd_index;
	beat_idx_t rd_beat;
	tag_t fill_tag;
	index_t fill_index;

	logic hit_any;
	logic [WAY_W-1:0] hit_way;

	// Address decode
	assign rd_tag = rd_addr[31:TAG_LSB];
	assign rd_index = rd_addr[TAG_LSB-1:`L1I_OFFSET_W];
	assign rd_beat = rd_addr[`L1I_OFFSET_W-1:3];
	assign fill_tag = fill.addr[31:TAG_LSB];
	assign fill_index = fill.addr[TAG_LSB-1:`L1I_OFFSET_W];

	// Tag compare across the ways of the set
	always_comb begin
		hit_any = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `L1I_WAYS; w++) begin
			if (valid_mem[rd_index][w] && (tag_mem[rd_index][w] == rd_tag)) begin
				hit_any = 1'b1;
				hit_way = w[WAY_W-1:0];
			end
		end
	end

	// Lookup status, held while the next stage is locked
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup.valid <= 1'b0;
			lookup.hit <= 1'b0;
		end
		else if (!hold) begin
			lookup.valid <= rd_req;
			// A flush in the request cycle turns the lookup into a miss
			lookup.hit <= rd_req && hit_any && !cache_flush;
		end
	end

	// Selected beat of the hit way
	always_ff @(posedge iCLOCK) begin
		if (rd_req && !hold) begin
			lookup.data <= data_mem[rd_index][hit_way][rd_beat*64 +: 64];
			lookup.flags <= flags_mem[rd_index][hit_way][rd_beat*24 +: 24];
		end
	end

	// Line and tag write into the victim way
	always_ff @(posedge iCLOCK) begin
		if (fill.req) begin
			tag_mem[fill_index][victim[fill_index]] <= fill_tag;
			data_mem[fill_index][victim[fill_index]] <= fill.data;
			flags_mem[fill_index][victim[fill_index]] <= fill.flags;
		end
	end

	// Valid bits and victim pointers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_mem <= '{default: '0};
			victim <= '{default: '0};
		end
		else begin
			if (fill.req) begin
				valid_mem[fill_index][victim[fill_index]] <= 1'b1;
				victim[fill_index] <= victim[fill_index] + 1'b1;
			end
			// Flush overrides a fill in the same cycle
			if (cache_flush) begin
				valid_mem <= '{default: '0};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/l1_icache_refill.sv ====
// Miss FSM: beat requests to memory, line gathering and requested pair capture
`default_nettype none
`include "l1_icache_consts.svh"

module l1_icache_refill import l1_icache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	l1_icache_lookup_if.sink lookup,
	input addr_t req_addr,
	input logic next_lock,
	output logic mem_req,
	output addr_t mem_addr,
	input logic mem_lock,
	input logic mem_valid,
	input beat_t mem_data,
	input beat_flags_t mem_flags,
	l1_icache_fill_if.master fill,
	output logic busy,
	output logic out_present,
	output beat_t out_beat,
	output beat_flags_t out_flags,
	output logic out_upper
);

	localparam beat_idx_t LAST_BEAT = beat_idx_t'(`L1I_LINE_BEATS - 1);

	refill_state_t state;

	// Separate counters for issued and returned beats
	beat_idx_t req_cnt;
	beat_idx_t get_cnt;

	addr_t miss_addr;
	line_t line_buf;
	line_flags_t flags_buf;
	beat_idx_t want_beat;
	logic miss_seen;

	assign miss_seen = lookup.valid && !lookup.hit && !next_lock;
	assign want_beat = miss_addr[`L1I_OFFSET_W-1:3];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= REFILL_IDLE;
			req_cnt <= '0;
			get_cnt <= '0;
		end
		else begin
			case (state)
				REFILL_IDLE: begin
					if (miss_seen) begin
						state <= REFILL_REQ;
						req_cnt <= '0;
						get_cnt <= '0;
					end
				end
				REFILL_REQ, REFILL_GET: begin
					// Request side only advances when memory takes the beat
					if ((state == REFILL_REQ) && !mem_lock) begin
						req_cnt <= req_cnt + 1'b1;
						if (req_cnt == LAST_BEAT) begin
							state <= REFILL_GET;
						end
					end
					if (mem_valid) begin
						get_cnt <= get_cnt + 1'b1;
						if (get_cnt == LAST_BEAT) begin
							state <= REFILL_OUT;
						end
					end
				end
				REFILL_OUT: begin
					if (!next_lock) begin
						state <= REFILL_IDLE;
					end
				end
				default: begin
					state <= REFILL_IDLE;
				end
			endcase
		end
	end

	// Miss address latched at the start of a refill
	always_ff @(posedge iCLOCK) begin
		if ((state == REFILL_IDLE) && miss_seen) begin
			miss_addr <= req_addr;
		end
	end

	// Beats shift in from the top, beat 0 ends up lowest
	always_ff @(posedge iCLOCK) begin
		if (mem_valid && ((state == REFILL_REQ) || (state == REFILL_GET))) begin
			line_buf <= {mem_data, line_buf[$bits(line_t)-1:$bits(beat_t)]};
			flags_buf <= {mem_flags, flags_buf[$bits(line_flags_t)-1:$bits(beat_flags_t)]};
			if (get_cnt == want_beat) begin
				out_beat <= mem_data;
				out_flags <= mem_flags;
			end
		end
	end

	// Memory request side
	assign mem_req = (state == REFILL_REQ);
	assign mem_addr = {miss_addr[31:`L1I_OFFSET_W], req_cnt, 3'b000};

	// Line write as the result leaves
	assign fill.req = (state == REFILL_OUT) && !next_lock;
	assign fill.addr = miss_addr;
	assign fill.data = line_buf;
	assign fill.flags = flags_buf;

	assign busy = (state != REFILL_IDLE);
	assign out_present = (state == REFILL_OUT);
	assign out_upper = miss_addr[2];

endmodule

`default_nettype wire

// ==== hw/l1_icache_fetch_out.sv ====
// Fetch acceptance, in-flight tracking and slot output selection
`default_nettype none

module l1_icache_fetch_out import l1_icache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic accepted,
	output addr_t req_addr,
	l1_icache_lookup_if.sink lookup,
	input logic refill_busy,
	input logic out_present,
	input beat_t out_beat,
	input beat_flags_t out_flags,
	input logic out_upper,
	input logic next_lock,
	output logic fetch_lock,
	output logic slot0_valid,
	output inst_t slot0_inst,
	output mmu_flags_t slot0_flags,
	output logic slot1_valid,
	output inst_t slot1_inst,
	output mmu_flags_t slot1_flags
);

	logic [1:0] inflight;
	logic result_avail;
	logic retire;
	logic upper;
	beat_t sel_beat;
	beat_flags_t sel_flags;

	// Stall on miss, refill or next stage lock
	assign fetch_lock = refill_busy || next_lock || (lookup.valid && !lookup.hit);
	assign accepted = fetch_req && !fetch_lock;

	always_ff @(posedge iCLOCK) begin
		if (accepted) begin
			req_addr <= fetch_addr;
		end
	end

	// Refill result takes priority over a hit
	assign result_avail = out_present || (lookup.valid && lookup.hit);
	assign retire = result_avail && (inflight != 2'd0) && !next_lock;
	assign upper = out_present ? out_upper : req_addr[2];
	assign sel_beat = out_present ? out_beat : lookup.data;
	assign sel_flags = out_present ? out_flags : lookup.flags;

	// Outstanding fetches, remove discards them
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inflight <= 2'd0;
		end
		else if (remove) begin
			inflight <= {1'b0, accepted};
		end
		else if (accepted && !retire) begin
			inflight <= inflight + 2'd1;
		end
		else if (!accepted && retire) begin
			inflight <= inflight - 2'd1;
		end
	end

	// Upper word moves to slot 0 for an odd word address
	assign slot0_valid = retire && !remove;
	assign slot0_inst = upper ? sel_beat[63:32] : sel_beat[31:0];
	assign slot0_flags = upper ? sel_flags[23:12] : sel_flags[11:0];
	assign slot1_valid = retire && !remove && !upper;
	assign slot1_inst = sel_beat[63:32];
	assign slot1_flags = sel_flags[23:12];

endmodule

`default_nettype wire

// ==== hw/l1_instruction_cache.sv ====
// Instruction cache top level joining storage, refill and fetch output blocks
`default_nettype none

module l1_instruction_cache import l1_icache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// Control
	input logic remove,
	input logic cache_flush,
	// Fetch side
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic fetch_lock,
	output logic slot0_valid,
	output inst_t slot0_inst,
	output mmu_flags_t slot0_flags,
	output logic slot1_valid,
	output inst_t slot1_inst,
	output mmu_flags_t slot1_flags,
	input logic next_lock,
	// Memory side
	output logic mem_req,
	output addr_t mem_addr,
	input logic mem_lock,
	input logic mem_valid,
	input beat_t mem_data,
	input beat_flags_t mem_flags
);

	logic accepted;
	addr_t req_addr;
	logic refill_busy;
	logic out_present;
	beat_t out_beat;
	beat_flags_t out_flags;
	logic out_upper;

	l1_icache_lookup_if lookup_bus ();
	l1_icache_fill_if fill_bus ();

	l1_icache_array array_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.cache_flush(cache_flush),
		.rd_req(accepted),
		.rd_addr(fetch_addr),
		.hold(next_lock),
		.lookup(lookup_bus.source),
		.fill(fill_bus.slave)
	);

	l1_icache_refill refill_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lookup(lookup_bus.sink),
		.req_addr(req_addr),
		.next_lock(next_lock),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.mem_flags(mem_flags),
		.fill(fill_bus.master),
		.busy(refill_busy),
		.out_present(out_present),
		.out_beat(out_beat),
		.out_flags(out_flags),
		.out_upper(out_upper)
	);

	l1_icache_fetch_out fetch_out_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.remove(remove),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.accepted(accepted),
		.req_addr(req_addr),
		.lookup(lookup_bus.sink),
		.refill_busy(refill_busy),
		.out_present(out_present),
		.out_beat(out_beat),
		.out_flags(out_flags),
		.out_upper(out_upper),
		.next_lock(next_lock),
		.fetch_lock(fetch_lock),
		.slot0_valid(slot0_valid),
		.slot0_inst(slot0_inst),
		.slot0_flags(slot0_flags),
		.slot1_valid(slot1_valid),
		.slot1_inst(slot1_inst),
		.slot1_flags(slot1_flags)
	);

endmodule

`default_nettype wire

// ==== bench/l1_icache_mem_model.sv ====
// Instruction memory model with address-derived beats, random lock and random return delay
`default_nettype none

module l1_icache_mem_model import l1_icache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic lock_rnd,
	input logic hold_rnd,
	input logic mem_req,
	input addr_t mem_addr,
	output logic mem_lock,
	output logic mem_valid,
	output beat_t mem_data,
	output beat_flags_t mem_flags
);

	timeunit 1ns;
	timeprecision 100ps;

	// Beat addresses taken but not yet returned
	addr_t pending [$];

	// Memory contents as a function of the word address
	function automatic inst_t word_at(addr_t a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic mmu_flags_t flags_at(addr_t a);
		return a[13:2] ^ a[25:14] ^ {6'h00, a[31:26]};
	endfunction

	initial begin
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_data = '0;
		mem_flags = '0;
	end

	always @(posedge iCLOCK) begin
		if ((inRESET === 1'b1) && mem_req && !mem_lock) begin
			pending.push_back({mem_addr[31:3], 3'b000});
		end
	end

	// Beats come back in order, some cycles are skipped
	always @(negedge iCLOCK) begin
		mem_lock = lock_rnd;
		mem_valid = (pending.size() != 0) && !hold_rnd;
		if (mem_valid) begin
			mem_data = {word_at(pending[0] + 32'd4), word_at(pending[0])};
			mem_flags = {flags_at(pending[0] + 32'd4), flags_at(pending[0])};
			void'(pending.pop_front());
		end
	end

endmodule

`default_nettype wire

// ==== bench/l1_icache_tb.sv ====
// Instruction cache testbench with directed and random fetches, reference model and checks
`default_nettype none
`include "l1_icache_consts.svh"

module l1_icache_tb import l1_icache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int STREAM_LEN = 60;
	localparam int DIRECTED_FETCHES = 20;
	localparam int WATCHDOG_CYCLES = 200 * (STREAM_LEN + DIRECTED_FETCHES);

	logic iCLOCK;
	logic inRESET;
	logic remove;
	logic cache_flush;
	logic fetch_req;
	addr_t fetch_addr;
	logic fetch_lock;
	logic slot0_valid;
	inst_t slot0_inst;
	mmu_flags_t slot0_flags;
	logic slot1_valid;
	inst_t slot1_inst;
	mmu_flags_t slot1_flags;
	logic next_lock;
	logic mem_req;
	addr_t mem_addr;
	logic mem_lock;
	logic mem_valid;
	beat_t mem_data;
	beat_flags_t mem_flags;

	logic lock_rnd;
	logic hold_rnd;
	logic lock_draw;
	logic stress;
	logic [31:0] lfsr;

	// Addresses of accepted fetches whose result is still due
	addr_t expected [$];
	int errors = 0;
	int accepts = 0;
	int results = 0;
	int removed = 0;
	int req_beats = 0;

	l1_instruction_cache l1_instruction_cache_i (.*);

	l1_icache_mem_model mem_model_i (.*);

	always #2 iCLOCK = ~iCLOCK;

	// Galois LFSR stepped once per bit
	function automatic logic rand_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], rand_bit()};
		end
		return v;
	endfunction

	// Expected {flags, instruction} of one word address
	function automatic logic [43:0] ref_word(addr_t a);
		inst_t inst;
		mmu_flags_t flags;
		inst = (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
		flags = a[13:2] ^ a[25:14] ^ {6'h00, a[31:26]};
		return {flags, inst};
	endfunction

	// Few tags over a few sets so random fetches both hit and evict
	function automatic addr_t random_addr();
		return 32'h0004_0000 | (rand_bits(3) << 10) | (rand_bits(2) << 6) | (rand_bits(4) << 2);
	endfunction

	task automatic check_inst(string name, inst_t got, inst_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flags(string name, mmu_flags_t got, mmu_flags_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_valid(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Memory lock, return delay and next-stage lock drawn each cycle
	always @(posedge iCLOCK) begin
		lock_rnd = rand_bit() & rand_bit();
		hold_rnd = rand_bit() & rand_bit();
		lock_draw = rand_bit();
	end

	always @(negedge iCLOCK) begin
		next_lock = stress && lock_draw;
	end

	// Each slot result is matched against the oldest outstanding fetch
	always @(posedge iCLOCK) begin
		addr_t a;
		logic [43:0] w0;
		logic [43:0] w1;
		if (inRESET === 1'b1) begin
			// A remove drops every outstanding fetch, so no result may show with it
			if (remove) begin
				removed += expected.size();
				expected.delete();
			end
			if (slot0_valid === 1'b1) begin
				if (expected.size() == 0) begin
					report_failure("slot output valid with no fetch outstanding");
				end
				else begin
					a = expected.pop_front();
					w0 = ref_word(a);
					w1 = ref_word(a + 32'd4);
					results++;
					check_inst("slot0_inst", slot0_inst, w0[31:0]);
					check_flags("slot0_flags", slot0_flags, w0[43:32]);
					check_valid("slot1_valid", slot1_valid, !a[2]);
					if (!a[2]) begin
						check_inst("slot1_inst", slot1_inst, w1[31:0]);
						check_flags("slot1_flags", slot1_flags, w1[43:32]);
					end
				end
			end
			else begin
				check_valid("slot0_valid", slot0_valid, 1'b0);
				check_valid("slot1_valid", slot1_valid, 1'b0);
			end
			if (fetch_req && !fetch_lock) begin
				accepts++;
				expected.push_back(fetch_addr);
			end
			if (mem_req && !mem_lock) begin
				req_beats++;
			end
		end
	end

	task automatic wait_accept();
		logic done;
		done = 1'b0;
		while (!done) begin
			@(posedge iCLOCK);
			done = fetch_req && !fetch_lock;
		end
	endtask

	// One fetch with hit or miss told apart by latency and memory traffic
	task automatic fetch_one(addr_t addr, logic exp_hit);
		int res_before;
		int beats_before;
		int lat;
		res_before = results;
		beats_before = req_beats;
		fetch_req = 1'b1;
		fetch_addr = addr;
		wait_accept();
		@(negedge iCLOCK);
		fetch_req = 1'b0;
		lat = 0;
		while (results == res_before) begin
			@(negedge iCLOCK);
			lat++;
		end
		if (exp_hit && (lat != 1)) begin
			report_failure($sformatf("fetch %h gave its hit result after %0d cycles", addr, lat));
		end
		if (exp_hit && (req_beats != beats_before)) begin
			report_failure($sformatf("fetch %h should hit but memory was requested", addr));
		end
		if (!exp_hit && (req_beats - beats_before != `L1I_LINE_BEATS)) begin
			report_failure($sformatf("fetch %h should miss but %0d beats were requested",
				addr, req_beats - beats_before));
		end
	endtask

	// Fetch discarded by a remove pulse some cycles after acceptance
	task automatic fetch_removed(addr_t addr, int delay);
		fetch_req = 1'b1;
		fetch_addr = addr;
		wait_accept();
		@(negedge iCLOCK);
		fetch_req = 1'b0;
		repeat (delay) @(negedge iCLOCK);
		remove = 1'b1;
		@(negedge iCLOCK);
		remove = 1'b0;
		while (fetch_lock) begin
			@(negedge iCLOCK);
		end
		repeat (2) @(negedge iCLOCK);
	endtask

	// Back-to-back random fetches followed by a wait for all results
	task automatic fetch_stream(int n);
		int sent;
		sent = 0;
		fetch_req = 1'b1;
		fetch_addr = random_addr();
		while (sent < n) begin
			wait_accept();
			sent++;
			@(negedge iCLOCK);
			if (sent < n) begin
				fetch_addr = random_addr();
			end
			else begin
				fetch_req = 1'b0;
			end
		end
		while (expected.size() != 0) begin
			@(negedge iCLOCK);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge iCLOCK);
		$display("Run stopped by the watchdog with %0d fetches still waiting", expected.size());
		$display("accepted %0d results %0d removed %0d errors %0d",
			accepts, results, removed, errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		remove = 1'b0;
		cache_flush = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		next_lock = 1'b0;
		stress = 1'b0;
		lfsr = 32'h6d9bf74f;
		repeat (4) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		check_valid("mem_req", mem_req, 1'b0);
		check_valid("fetch_lock", fetch_lock, 1'b0);
		check_valid("slot0_valid", slot0_valid, 1'b0);
		check_valid("slot1_valid", slot1_valid, 1'b0);

		// Cold miss followed by hits in the same line
		fetch_one(32'h0001_2348, 1'b0);
		fetch_one(32'h0001_2370, 1'b1);
		fetch_one(32'h0001_2348, 1'b1);

		// Odd word addresses fill slot 0 only
		fetch_one(32'h0001_2364, 1'b1);
		fetch_one(32'h0002_2384, 1'b0);
		fetch_one(32'h0002_23b8, 1'b1);

		// Five tags in set 5 evict way 0 first
		for (int i = 0; i < 5; i++) begin
			fetch_one(32'h0004_0148 + i * 32'h400, 1'b0);
		end
		fetch_one(32'h0004_0948, 1'b1);
		fetch_one(32'h0004_0148, 1'b0);

		cache_flush = 1'b1;
		@(negedge iCLOCK);
		cache_flush = 1'b0;
		fetch_one(32'h0004_0948, 1'b0);
		fetch_one(32'h0004_1148, 1'b0);
		fetch_one(32'h0001_2348, 1'b0);

		// Remove during a refill and on a hit result
		fetch_removed(32'h0003_0010, 3);
		fetch_one(32'h0003_0010, 1'b1);
		fetch_removed(32'h0003_0018, 0);
		fetch_one(32'h0003_001c, 1'b1);

		@(posedge iCLOCK);
		stress = 1'b1;
		@(negedge iCLOCK);
		fetch_stream(STREAM_LEN);
		@(posedge iCLOCK);
		stress = 1'b0;
		repeat (4) @(negedge iCLOCK);

		$display("accepted %0d results %0d removed %0d errors %0d",
			accepts, results, removed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end
		else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== l1_instruction_cache.f ====
+incdir+hw
hw/l1_icache_pkg.sv
hw/l1_icache_if.sv
hw/l1_icache_array.sv
hw/l1_icache_refill.sv
hw/l1_icache_fetch_out.sv
hw/l1_instruction_cache.sv
bench/l1_icache_mem_model.sv
bench/l1_icache_tb.sv

// ==== Bender.yml ====
package:
  name: l1_instruction_cache

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/l1_icache_pkg.sv
      - hw/l1_icache_if.sv
      - hw/l1_icache_array.sv
      - hw/l1_icache_refill.sv
      - hw/l1_icache_fetch_out.sv
      - hw/l1_instruction_cache.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/l1_icache_mem_model.sv
      - bench/l1_icache_tb.sv
